//--- build.f
design/cache_cfg_pkg.sv
design/cache_types_pkg.sv
design/cache_ram.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/cache_top.sv
test/tb_clock.sv
test/cache_assert.sv
test/cache_tb.sv

//--- design/cache_cfg_pkg.sv
package cache_cfg_pkg;

	// byte address split: tag | index | offset
	localparam int ADDR_LEN = 32;
	localparam int OFFSET_LEN = 4;
	localparam int INDEX_LEN = 4;
	localparam int TAG_LEN = ADDR_LEN - INDEX_LEN - OFFSET_LEN;

	// geometry
	localparam int WAY_NUM = 2;
	localparam int WAY_LEN = $clog2(WAY_NUM);
	localparam int SET_NUM = 1 << INDEX_LEN;

	// processor word and byte strobes
	localparam int DATA_LEN = 64;
	localparam int STRB_LEN = DATA_LEN / 8;

	// line made of two words
	localparam int WORDS_PER_LINE = 2;
	localparam int LINE_LEN = DATA_LEN * WORDS_PER_LINE;

	// offset bit that picks the upper word
	localparam int WORD_SEL_BIT = 3;

endpackage

//--- design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input  logic clk,
	input  logic rst,
	// processor side
	input  logic req_valid,
	input  cache_types_pkg::cache_op_e req_op,
	input  logic [cache_cfg_pkg::ADDR_LEN-1:0] addr,
	input  logic [cache_cfg_pkg::STRB_LEN-1:0] wstrb,
	input  logic [cache_cfg_pkg::DATA_LEN-1:0] wdata,
	output logic addr_ok,
	output logic data_ok,
	output logic [cache_cfg_pkg::DATA_LEN-1:0] rdata,
	// array side
	output logic lookup_en,
	output cache_types_pkg::cache_req_t lookup,
	input  logic hit,
	input  logic [cache_cfg_pkg::WAY_LEN-1:0] hit_way,
	input  cache_types_pkg::tag_entry_t victim,
	input  logic [cache_cfg_pkg::WAY_LEN-1:0] victim_way,
	input  logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::DATA_LEN-1:0] arr_rdata,
	input  logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::LINE_LEN-1:0] arr_line,
	output cache_types_pkg::data_wr_t data_wr,
	output logic data_wr_en,
	output logic tag_wr_en,
	output logic [cache_cfg_pkg::WAY_LEN-1:0] tag_wr_way,
	output logic [cache_cfg_pkg::INDEX_LEN-1:0] tag_wr_index,
	output cache_types_pkg::tag_entry_t tag_wr_entry,
	output logic dirty_set_en,
	output logic [cache_cfg_pkg::WAY_LEN-1:0] dirty_set_way,
	output logic [cache_cfg_pkg::INDEX_LEN-1:0] dirty_set_index,
	// memory side
	output logic wr_req,
	output cache_types_pkg::mem_wb_t wr_line,
	input  logic wr_ready,
	output logic rd_req,
	output logic [cache_cfg_pkg::ADDR_LEN-1:0] rd_addr,
	input  logic rd_beat_valid,
	input  logic rd_beat_last,
	input  logic [cache_cfg_pkg::DATA_LEN-1:0] rd_data
);

	cache_types_pkg::cache_state_e state_q, state_d;
	cache_types_pkg::cache_req_t req_q;
	// way being stored to or refilled
	logic [cache_cfg_pkg::WAY_LEN-1:0] mb_way;
	cache_types_pkg::tag_entry_t mb_victim;
	logic [cache_cfg_pkg::LINE_LEN-1:0] mb_line;
	logic beat_q;
	logic [cache_cfg_pkg::DATA_LEN-1:0] fill_word_q;
	logic req_beat;
	logic store_beat;

	assign lookup_en = (state_q == cache_types_pkg::S_IDLE) && req_valid;

	always_comb begin
		lookup.op = req_op;
		lookup.tag = addr[cache_cfg_pkg::ADDR_LEN-1 -: cache_cfg_pkg::TAG_LEN];
		lookup.index = addr[cache_cfg_pkg::OFFSET_LEN +: cache_cfg_pkg::INDEX_LEN];
		lookup.offset = addr[cache_cfg_pkg::OFFSET_LEN-1:0];
		lookup.wstrb = wstrb;
		lookup.wdata = wdata;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_types_pkg::S_IDLE: begin
				if (req_valid)
					state_d = cache_types_pkg::S_LOOKUP;
			end
			cache_types_pkg::S_LOOKUP: begin
				if (hit && req_q.op == cache_types_pkg::OP_WRITE)
					state_d = cache_types_pkg::S_STORE;
				else if (hit)
					state_d = cache_types_pkg::S_IDLE;
				else if (victim.valid && victim.dirty)
					state_d = cache_types_pkg::S_WRITEBACK;
				else
					state_d = cache_types_pkg::S_REFILL;
			end
			cache_types_pkg::S_STORE: state_d = cache_types_pkg::S_IDLE;
			cache_types_pkg::S_WRITEBACK: begin
				if (wr_ready)
					state_d = cache_types_pkg::S_REFILL;
			end
			cache_types_pkg::S_REFILL: begin
				if (rd_beat_valid && rd_beat_last)
					state_d = cache_types_pkg::S_DONE;
			end
			cache_types_pkg::S_DONE: state_d = cache_types_pkg::S_IDLE;
			default: state_d = cache_types_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= cache_types_pkg::S_IDLE;
			rd_req <= 1'b0;
		end else begin
			state_q <= state_d;
			// single pulse on entry to refill
			rd_req <= (state_d == cache_types_pkg::S_REFILL) &&
				(state_q != cache_types_pkg::S_REFILL);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state_q != cache_types_pkg::S_REFILL)
			beat_q <= 1'b0;
		else if (rd_beat_valid)
			beat_q <= ~beat_q;
	end

	assign req_beat = (beat_q == req_q.offset[cache_cfg_pkg::WORD_SEL_BIT]);
	assign store_beat = req_beat && (req_q.op == cache_types_pkg::OP_WRITE);

	always_ff @(posedge clk) begin
		if (lookup_en)
			req_q <= lookup;
		if (state_q == cache_types_pkg::S_LOOKUP) begin
			mb_way <= hit ? hit_way : victim_way;
			mb_victim <= victim;
			mb_line <= arr_line[victim_way];
		end
		if (state_q == cache_types_pkg::S_REFILL && rd_beat_valid && req_beat)
			fill_word_q <= rd_data;
	end

	// store hit merges in the array, refill beats are merged here
	always_comb begin
		data_wr_en = 1'b0;
		data_wr.way = mb_way;
		data_wr.index = req_q.index;
		data_wr.word = req_q.offset[cache_cfg_pkg::WORD_SEL_BIT];
		data_wr.strb = req_q.wstrb;
		data_wr.data = req_q.wdata;
		if (state_q == cache_types_pkg::S_REFILL) begin
			data_wr_en = rd_beat_valid;
			data_wr.word = beat_q;
			data_wr.strb = '1;
			data_wr.data = store_beat ?
				cache_types_pkg::merge_bytes(rd_data, req_q.wdata, req_q.wstrb) : rd_data;
		end else if (state_q == cache_types_pkg::S_STORE) begin
			data_wr_en = 1'b1;
		end
	end

	// new tag goes in with the last beat
	assign tag_wr_en = (state_q == cache_types_pkg::S_REFILL) && rd_beat_valid && rd_beat_last;
	assign tag_wr_way = mb_way;
	assign tag_wr_index = req_q.index;
	assign tag_wr_entry.valid = 1'b1;
	assign tag_wr_entry.dirty = (req_q.op == cache_types_pkg::OP_WRITE);
	assign tag_wr_entry.tag = req_q.tag;

	assign dirty_set_en = (state_q == cache_types_pkg::S_STORE);
	assign dirty_set_way = mb_way;
	assign dirty_set_index = req_q.index;

	assign wr_req = (state_q == cache_types_pkg::S_WRITEBACK);
	assign wr_line.line_addr = {mb_victim.tag, req_q.index};
	assign wr_line.data = mb_line;
	assign rd_addr = {req_q.tag, req_q.index, {cache_cfg_pkg::OFFSET_LEN{1'b0}}};

	assign addr_ok = (state_q == cache_types_pkg::S_IDLE);
	assign data_ok = (state_q == cache_types_pkg::S_LOOKUP && hit) ||
		(state_q == cache_types_pkg::S_DONE);
	assign rdata = (state_q == cache_types_pkg::S_DONE) ? fill_word_q : arr_rdata[hit_way];

endmodule

//--- design/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
	input  logic clk,
	input  logic rst,
	input  logic rd_en,
	input  logic [cache_cfg_pkg::INDEX_LEN-1:0] rd_index,
	input  logic rd_word,
	output logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::DATA_LEN-1:0] rd_data,
	output logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::LINE_LEN-1:0] line_out,
	input  cache_types_pkg::data_wr_t wr,
	input  logic wr_en
);

	logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::WORDS_PER_LINE-1:0]
		[cache_cfg_pkg::DATA_LEN-1:0] bank_dout;
	logic rd_word_q;

	// one bank per way and word
	for (genvar w = 0; w < cache_cfg_pkg::WAY_NUM; w++) begin : g_way
		for (genvar k = 0; k < cache_cfg_pkg::WORDS_PER_LINE; k++) begin : g_word
			logic bank_we;
			logic [cache_cfg_pkg::DATA_LEN-1:0] bank_din;

			assign bank_we = wr_en && (wr.way == w) && (wr.word == k);
			// unstrobed bytes keep the word read out at lookup
			assign bank_din = cache_types_pkg::merge_bytes(bank_dout[w][k], wr.data, wr.strb);

			cache_ram #(
				.WIDTH(cache_cfg_pkg::DATA_LEN),
				.DEPTH(cache_cfg_pkg::SET_NUM)
			) u_bank (
				.clk(clk),
				.rst(rst),
				.cs(rd_en | bank_we),
				.we(bank_we),
				.addr(bank_we ? wr.index : rd_index),
				.din(bank_din),
				.dout(bank_dout[w][k])
			);
		end

		assign rd_data[w] = bank_dout[w][rd_word_q];
		assign line_out[w] = bank_dout[w];
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_word_q <= rd_word;
	end

endmodule

//--- design/cache_ram.sv
`timescale 1ns/1ps

module cache_ram #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic cs,
	input  logic we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	// read returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
			dout <= '0;
		end else if (cs) begin
			dout <= mem[addr];
			if (we)
				mem[addr] <= din;
		end
	end

endmodule

//--- design/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
	input  logic clk,
	input  logic rst,
	input  logic lookup_en,
	input  cache_types_pkg::cache_req_t lookup,
	output logic hit,
	output logic [cache_cfg_pkg::WAY_LEN-1:0] hit_way,
	output cache_types_pkg::tag_entry_t victim,
	output logic [cache_cfg_pkg::WAY_LEN-1:0] victim_way,
	input  logic tag_wr_en,
	input  logic [cache_cfg_pkg::WAY_LEN-1:0] tag_wr_way,
	input  logic [cache_cfg_pkg::INDEX_LEN-1:0] tag_wr_index,
	input  cache_types_pkg::tag_entry_t tag_wr_entry,
	input  logic dirty_set_en,
	input  logic [cache_cfg_pkg::WAY_LEN-1:0] dirty_set_way,
	input  logic [cache_cfg_pkg::INDEX_LEN-1:0] dirty_set_index
);

	cache_types_pkg::tag_entry_t [cache_cfg_pkg::WAY_NUM-1:0] entry;
	logic [cache_cfg_pkg::WAY_NUM-1:0] way_hit;
	logic [cache_cfg_pkg::TAG_LEN-1:0] tag_q;
	logic [cache_cfg_pkg::INDEX_LEN-1:0] index_q;
	// per-set round-robin pointer
	logic [cache_cfg_pkg::SET_NUM-1:0] rr_q;

	for (genvar w = 0; w < cache_cfg_pkg::WAY_NUM; w++) begin : g_way
		logic wr_sel;
		logic dirty_sel;
		logic [cache_cfg_pkg::INDEX_LEN-1:0] ram_addr;
		cache_types_pkg::tag_entry_t ram_din;

		assign wr_sel = tag_wr_en && (tag_wr_way == w);
		assign dirty_sel = dirty_set_en && (dirty_set_way == w);

		always_comb begin
			ram_addr = lookup.index;
			ram_din = tag_wr_entry;
			if (wr_sel) begin
				ram_addr = tag_wr_index;
			end else if (dirty_sel) begin
				// entry still holds the lookup read of this set
				ram_addr = dirty_set_index;
				ram_din = entry[w];
				ram_din.dirty = 1'b1;
			end
		end

		cache_ram #(
			.WIDTH($bits(cache_types_pkg::tag_entry_t)),
			.DEPTH(cache_cfg_pkg::SET_NUM)
		) u_tag_ram (
			.clk(clk),
			.rst(rst),
			.cs(lookup_en | wr_sel | dirty_sel),
			.we(wr_sel | dirty_sel),
			.addr(ram_addr),
			.din(ram_din),
			.dout(entry[w])
		);

		assign way_hit[w] = entry[w].valid && (entry[w].tag == tag_q);
	end

	always_ff @(posedge clk) begin
		if (lookup_en) begin
			tag_q <= lookup.tag;
			index_q <= lookup.index;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rr_q <= '0;
		else if (tag_wr_en)
			rr_q[tag_wr_index] <= ~rr_q[tag_wr_index];
	end

	assign hit = |way_hit;

	always_comb begin
		hit_way = '0;
		for (int i = 0; i < cache_cfg_pkg::WAY_NUM; i++) begin
			if (way_hit[i])
				hit_way = cache_cfg_pkg::WAY_LEN'(i);
		end
	end

	// lowest invalid way wins, else round robin
	always_comb begin
		victim_way = rr_q[index_q];
		for (int i = cache_cfg_pkg::WAY_NUM - 1; i >= 0; i--) begin
			if (!entry[i].valid)
				victim_way = cache_cfg_pkg::WAY_LEN'(i);
		end
	end

	assign victim = entry[victim_way];

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

module cache_top (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_types_pkg::cache_op_e req_op,
	input  logic [cache_cfg_pkg::ADDR_LEN-1:0] addr,
	input  logic [cache_cfg_pkg::STRB_LEN-1:0] wstrb,
	input  logic [cache_cfg_pkg::DATA_LEN-1:0] wdata,
	output logic addr_ok,
	output logic data_ok,
	output logic [cache_cfg_pkg::DATA_LEN-1:0] rdata,
	output logic wr_req,
	output cache_types_pkg::mem_wb_t wr_line,
	input  logic wr_ready,
	output logic rd_req,
	output logic [cache_cfg_pkg::ADDR_LEN-1:0] rd_addr,
	input  logic rd_beat_valid,
	input  logic rd_beat_last,
	input  logic [cache_cfg_pkg::DATA_LEN-1:0] rd_data
);

	logic lookup_en;
	cache_types_pkg::cache_req_t lookup;
	logic hit;
	logic [cache_cfg_pkg::WAY_LEN-1:0] hit_way;
	cache_types_pkg::tag_entry_t victim;
	logic [cache_cfg_pkg::WAY_LEN-1:0] victim_way;
	logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::DATA_LEN-1:0] word_rdata;
	logic [cache_cfg_pkg::WAY_NUM-1:0][cache_cfg_pkg::LINE_LEN-1:0] line_data;
	cache_types_pkg::data_wr_t data_wr;
	logic data_wr_en;
	logic tag_wr_en;
	logic [cache_cfg_pkg::WAY_LEN-1:0] tag_wr_way;
	logic [cache_cfg_pkg::INDEX_LEN-1:0] tag_wr_index;
	cache_types_pkg::tag_entry_t tag_wr_entry;
	logic dirty_set_en;
	logic [cache_cfg_pkg::WAY_LEN-1:0] dirty_set_way;
	logic [cache_cfg_pkg::INDEX_LEN-1:0] dirty_set_index;

	cache_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_op(req_op), .addr(addr), .wstrb(wstrb), .wdata(wdata),
		.addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
		.lookup_en(lookup_en), .lookup(lookup),
		.hit(hit), .hit_way(hit_way), .victim(victim), .victim_way(victim_way),
		.arr_rdata(word_rdata), .arr_line(line_data),
		.data_wr(data_wr), .data_wr_en(data_wr_en),
		.tag_wr_en(tag_wr_en), .tag_wr_way(tag_wr_way), .tag_wr_index(tag_wr_index),
		.tag_wr_entry(tag_wr_entry),
		.dirty_set_en(dirty_set_en), .dirty_set_way(dirty_set_way),
		.dirty_set_index(dirty_set_index),
		.wr_req(wr_req), .wr_line(wr_line), .wr_ready(wr_ready),
		.rd_req(rd_req), .rd_addr(rd_addr),
		.rd_beat_valid(rd_beat_valid), .rd_beat_last(rd_beat_last), .rd_data(rd_data)
	);

	cache_tag_array u_tag_array (
		.clk(clk), .rst(rst),
		.lookup_en(lookup_en), .lookup(lookup),
		.hit(hit), .hit_way(hit_way), .victim(victim), .victim_way(victim_way),
		.tag_wr_en(tag_wr_en), .tag_wr_way(tag_wr_way), .tag_wr_index(tag_wr_index),
		.tag_wr_entry(tag_wr_entry),
		.dirty_set_en(dirty_set_en), .dirty_set_way(dirty_set_way),
		.dirty_set_index(dirty_set_index)
	);

	// word select comes straight from the lookup offset
	cache_data_array u_data_array (
		.clk(clk), .rst(rst),
		.rd_en(lookup_en), .rd_index(lookup.index),
		.rd_word(lookup.offset[cache_cfg_pkg::WORD_SEL_BIT]),
		.rd_data(word_rdata), .line_out(line_data),
		.wr(data_wr), .wr_en(data_wr_en)
	);

endmodule

//--- design/cache_types_pkg.sv
package cache_types_pkg;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cache_op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_STORE,
		S_WRITEBACK,
		S_REFILL,
		S_DONE
	} cache_state_e;

	typedef struct packed {
		cache_op_e op;
		logic [cache_cfg_pkg::TAG_LEN-1:0] tag;
		logic [cache_cfg_pkg::INDEX_LEN-1:0] index;
		logic [cache_cfg_pkg::OFFSET_LEN-1:0] offset;
		logic [cache_cfg_pkg::STRB_LEN-1:0] wstrb;
		logic [cache_cfg_pkg::DATA_LEN-1:0] wdata;
	} cache_req_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [cache_cfg_pkg::TAG_LEN-1:0] tag;
	} tag_entry_t;

	// line address is tag and index, offset implied zero
	typedef struct packed {
		logic [cache_cfg_pkg::TAG_LEN+cache_cfg_pkg::INDEX_LEN-1:0] line_addr;
		logic [cache_cfg_pkg::LINE_LEN-1:0] data;
	} mem_wb_t;

	typedef struct packed {
		logic [cache_cfg_pkg::WAY_LEN-1:0] way;
		logic [cache_cfg_pkg::INDEX_LEN-1:0] index;
		logic word;
		logic [cache_cfg_pkg::STRB_LEN-1:0] strb;
		logic [cache_cfg_pkg::DATA_LEN-1:0] data;
	} data_wr_t;

	// byte-wise merge, strobe picks the new byte
	function automatic logic [cache_cfg_pkg::DATA_LEN-1:0] merge_bytes(
		input logic [cache_cfg_pkg::DATA_LEN-1:0] old_word,
		input logic [cache_cfg_pkg::DATA_LEN-1:0] new_word,
		input logic [cache_cfg_pkg::STRB_LEN-1:0] strb
	);
		logic [cache_cfg_pkg::DATA_LEN-1:0] res;
		res = old_word;
		for (int i = 0; i < cache_cfg_pkg::STRB_LEN; i++) begin
			if (strb[i])
				res[i*8 +: 8] = new_word[i*8 +: 8];
		end
		return res;
	endfunction

endpackage

//--- test/cache_assert.sv
`timescale 1ns/1ps

module cache_assert (
	input  logic clk,
	input  logic rst,
	input  logic wr_req,
	input  cache_types_pkg::mem_wb_t wr_line,
	input  logic wr_ready,
	input  logic rd_req,
	input  logic addr_ok,
	input  logic data_ok
);

	int fail_count = 0;

	// write-back request holds until the memory takes it
	wb_hold: assert property (@(posedge clk) disable iff (rst)
		wr_req && !wr_ready |=> wr_req && $stable(wr_line))
	else begin
		fail_count++;
		$error("wr_req dropped or wr_line changed before wr_ready");
	end

	rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
	else begin
		fail_count++;
		$error("rd_req and wr_req high in the same cycle");
	end

	ok_excl: assert property (@(posedge clk) disable iff (rst) !(data_ok && addr_ok))
	else begin
		fail_count++;
		$error("data_ok and addr_ok high in the same cycle");
	end

	// data_ok is a single-cycle pulse
	ok_pulse: assert property (@(posedge clk) disable iff (rst) data_ok |=> !data_ok)
	else begin
		fail_count++;
		$error("data_ok high in two cycles in a row");
	end

endmodule

bind cache_ctrl cache_assert u_assert (
	.clk(clk),
	.rst(rst),
	.wr_req(wr_req),
	.wr_line(wr_line),
	.wr_ready(wr_ready),
	.rd_req(rd_req),
	.addr_ok(addr_ok),
	.data_ok(data_ok)
);

//--- test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h743e;

	logic clk;
	logic rst;
	logic req_valid;
	cache_types_pkg::cache_op_e req_op;
	logic [31:0] addr;
	logic [7:0] wstrb;
	logic [63:0] wdata;
	logic addr_ok;
	logic data_ok;
	logic [63:0] rdata;
	logic wr_req;
	cache_types_pkg::mem_wb_t wr_line;
	logic wr_ready;
	logic rd_req;
	logic [31:0] rd_addr;
	logic rd_beat_valid;
	logic rd_beat_last;
	logic [63:0] rd_data;

	// sparse memory, keyed by word address
	logic [63:0] mem_words [logic [28:0]];
	logic [31:0] rng;
	int rd_count;
	int wb_count;
	logic [31:0] rd_seen_addr;
	logic [27:0] wb_seen_addr;
	logic [127:0] wb_seen_data;

	// shadow of the cache contents
	logic m_valid [16][2];
	logic m_dirty [16][2];
	logic [23:0] m_tag [16][2];
	logic [63:0] m_data [16][2][2];
	logic m_rr [16];

	int err_count;
	int tests_passed;
	int tests_failed;
	logic timed_out;

	tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

	cache_top cache_top_i (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_op(req_op), .addr(addr), .wstrb(wstrb), .wdata(wdata),
		.addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
		.wr_req(wr_req), .wr_line(wr_line), .wr_ready(wr_ready),
		.rd_req(rd_req), .rd_addr(rd_addr),
		.rd_beat_valid(rd_beat_valid), .rd_beat_last(rd_beat_last), .rd_data(rd_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// words never written follow a pattern of the whole word address
	function automatic logic [63:0] mem_read(input logic [28:0] wa);
		if (mem_words.exists(wa))
			return mem_words[wa];
		return {xorshift32({3'b000, wa} ^ SEED), xorshift32(~{3'b000, wa} ^ SEED)};
	endfunction

	function automatic logic [63:0] apply_strobes(input logic [63:0] old_w,
		input logic [63:0] new_w, input logic [7:0] s);
		logic [63:0] r;
		for (int b = 0; b < 8; b++)
			r[b*8 +: 8] = s[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
		return r;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		err_count++;
		timed_out = 1'b1;
		$display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
	endtask

	task automatic report_test(input int id, input int errs);
		if (errs == 0) begin
			tests_passed++;
			$display("test %0d: ok", id);
		end else begin
			tests_failed++;
			$display("test %0d: %0d errors", id, errs);
		end
	endtask

	// hit, victim and write-back prediction, then update of the shadow
	task automatic model_access(input logic is_write, input logic [31:0] a,
		input logic [7:0] s, input logic [63:0] wd, output logic hit,
		output logic [63:0] rd_exp, output logic wb, output logic [27:0] wb_addr,
		output logic [127:0] wb_data);
		logic [23:0] tag;
		logic [3:0] set;
		logic word;
		int way;
		tag = a[31:8];
		set = a[7:4];
		word = a[3];
		hit = 1'b0;
		wb = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		way = 0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[set][w] && m_tag[set][w] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			if (!m_valid[set][0])
				way = 0;
			else if (!m_valid[set][1])
				way = 1;
			else
				way = m_rr[set];
			wb = m_valid[set][way] && m_dirty[set][way];
			wb_addr = {m_tag[set][way], set};
			wb_data = {m_data[set][way][1], m_data[set][way][0]};
			m_data[set][way][0] = mem_read({a[31:4], 1'b0});
			m_data[set][way][1] = mem_read({a[31:4], 1'b1});
			m_tag[set][way] = tag;
			m_valid[set][way] = 1'b1;
			m_dirty[set][way] = 1'b0;
			m_rr[set] = ~m_rr[set];
		end
		rd_exp = m_data[set][way][word];
		if (is_write) begin
			m_data[set][way][word] = apply_strobes(m_data[set][way][word], wd, s);
			m_dirty[set][way] = 1'b1;
		end
	endtask

	task automatic run_request(input int op, input logic [31:0] a, input logic [7:0] s,
		input logic [63:0] wd, input logic [63:0] ex);
		logic is_write;
		logic exp_hit;
		logic [63:0] exp_rdata;
		logic exp_wb;
		logic [27:0] exp_wb_addr;
		logic [127:0] exp_wb_data;
		int n;
		is_write = (op == 1);
		model_access(is_write, a, s, wd, exp_hit, exp_rdata, exp_wb, exp_wb_addr, exp_wb_data);
		n = 0;
		while (!addr_ok && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!addr_ok) begin
			note_timeout("addr_ok before a request");
			return;
		end
		rd_count = 0;
		wb_count = 0;
		req_valid = 1'b1;
		req_op = is_write ? cache_types_pkg::OP_WRITE : cache_types_pkg::OP_READ;
		addr = a;
		wstrb = is_write ? s : 8'h00;
		wdata = wd;
		@(negedge clk);
		req_valid = 1'b0;
		// n counts cycles since acceptance
		n = 1;
		while (!data_ok && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!data_ok) begin
			note_timeout("data_ok");
			return;
		end
		if (!is_write)
			check_value("rdata", rdata, exp_rdata);
		if (op == 2)
			check_value("rdata against data file", rdata, ex);
		if (exp_hit)
			check_value("data_ok latency", n, 1);
		check_value("rd_req count", rd_count, exp_hit ? 0 : 1);
		if (!exp_hit)
			check_value("rd_addr", rd_seen_addr, {a[31:4], 4'h0});
		check_value("wr_req count", wb_count, exp_wb);
		if (exp_wb) begin
			check_value("wr_line.line_addr", wb_seen_addr, exp_wb_addr);
			check_value("wr_line.data", wb_seen_data, exp_wb_data);
		end
		if (exp_hit && !is_write) begin
			@(negedge clk);
			check_value("addr_ok after read hit", addr_ok, 1);
		end
	endtask

	// memory side, answers write-backs and refills
	initial begin
		int d;
		logic [28:0] wa;
		rng = SEED;
		@(negedge clk);
		forever begin
			if (wr_req) begin
				wb_count++;
				wb_seen_addr = wr_line.line_addr;
				wb_seen_data = wr_line.data;
				mem_words[{wr_line.line_addr, 1'b0}] = wr_line.data[63:0];
				mem_words[{wr_line.line_addr, 1'b1}] = wr_line.data[127:64];
				rng = xorshift32(rng);
				d = 1 + int'(rng % 4);
				repeat (d) @(negedge clk);
				wr_ready = 1'b1;
				@(negedge clk);
				wr_ready = 1'b0;
			end else if (rd_req) begin
				rd_count++;
				rd_seen_addr = rd_addr;
				wa = rd_addr[31:3];
				rng = xorshift32(rng);
				d = 2 + int'(rng % 4);
				repeat (d) @(negedge clk);
				rd_beat_valid = 1'b1;
				rd_beat_last = 1'b0;
				rd_data = mem_read(wa);
				@(negedge clk);
				// one idle cycle between the beats
				rd_beat_valid = 1'b0;
				@(negedge clk);
				rd_beat_valid = 1'b1;
				rd_beat_last = 1'b1;
				rd_data = mem_read(wa + 29'd1);
				@(negedge clk);
				rd_beat_valid = 1'b0;
				rd_beat_last = 1'b0;
			end else begin
				@(negedge clk);
			end
		end
	end

	initial begin
		int fd;
		int n;
		int id;
		int op;
		int cur_id;
		int grp_err;
		logic [31:0] a;
		logic [7:0] s;
		logic [63:0] wd;
		logic [63:0] ex;
		string line;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = cache_types_pkg::OP_READ;
		addr = '0;
		wstrb = '0;
		wdata = '0;
		wr_ready = 1'b0;
		rd_beat_valid = 1'b0;
		rd_beat_last = 1'b0;
		rd_data = '0;
		rd_count = 0;
		wb_count = 0;
		for (int i = 0; i < 16; i++) begin
			m_rr[i] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_valid[i][w] = 1'b0;
				m_dirty[i][w] = 1'b0;
				m_tag[i][w] = '0;
				m_data[i][w][0] = '0;
				m_data[i][w][1] = '0;
			end
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		// idle outputs after reset
		grp_err = err_count;
		check_value("addr_ok", addr_ok, 1);
		check_value("data_ok", data_ok, 0);
		check_value("rd_req", rd_req, 0);
		check_value("wr_req", wr_req, 0);
		report_test(0, err_count - grp_err);
		fd = $fopen("test/cache_testdata.txt", "r");
		if (fd == 0) begin
			err_count++;
			$display("could not open test/cache_testdata.txt");
		end else begin
			cur_id = -1;
			while (!timed_out && $fgets(line, fd) != 0) begin
				n = $sscanf(line, "%d %d %h %h %h %h", id, op, a, s, wd, ex);
				if (n == 6) begin
					if (id != cur_id) begin
						if (cur_id >= 0)
							report_test(cur_id, err_count - grp_err);
						cur_id = id;
						grp_err = err_count;
					end
					run_request(op, a, s, wd, ex);
				end
			end
			if (cur_id >= 0)
				report_test(cur_id, err_count - grp_err);
			$fclose(fd);
		end
		err_count += cache_top_i.u_ctrl.u_assert.fail_count;
		$display("tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
			tests_passed, tests_failed, err_count, cache_top_i.u_ctrl.u_assert.fail_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- test/cache_testdata.txt
# columns: test id, op (0 read, 1 write, 2 read also checked against the last column),
# byte address, strobes, write data, expected read data (last four in hex)
1 0 00001000 00 0000000000000000 0000000000000000
1 0 000a5c48 00 0000000000000000 0000000000000000
2 0 00001008 00 0000000000000000 0000000000000000
2 0 00001000 00 0000000000000000 0000000000000000
2 0 000a5c40 00 0000000000000000 0000000000000000
2 0 000a5c48 00 0000000000000000 0000000000000000
3 1 00002010 ff 1122334455667788 0000000000000000
3 1 00002010 0f aaaaaaaabbbbbbbb 0000000000000000
3 2 00002010 00 0000000000000000 11223344bbbbbbbb
3 1 00002010 81 cc000000000000dd 0000000000000000
3 2 00002010 00 0000000000000000 cc223344bbbbbbdd
3 1 00002018 c0 5a5a000000000000 0000000000000000
3 0 00002018 00 0000000000000000 0000000000000000
4 1 00003028 3c 0000deadbeef0000 0000000000000000
4 0 00003028 00 0000000000000000 0000000000000000
4 0 00003020 00 0000000000000000 0000000000000000
5 1 00004030 ff 0123456789abcdef 0000000000000000
5 0 00005030 00 0000000000000000 0000000000000000
5 0 00006030 00 0000000000000000 0000000000000000
5 0 00007038 00 0000000000000000 0000000000000000
5 2 00004030 00 0000000000000000 0123456789abcdef
5 1 00007038 ff fedcba9876543210 0000000000000000
5 0 00008030 00 0000000000000000 0000000000000000
5 2 00007038 00 0000000000000000 fedcba9876543210
5 0 00008038 00 0000000000000000 0000000000000000
5 0 00004038 00 0000000000000000 0000000000000000

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule
